/* src.f */
posit_pkg.sv
ppu_pkg.sv
posit_decode.sv
core_add_sub.sv
core_div.sv
core_op.sv
posit_encode.sv
ppu_result_queue.sv
ppu.sv
ppu_sva.sv
tb_ppu.sv

/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu \
		-f src.f --Mdir obj_dir -o Vtb_ppu

run: compile
	./obj_dir/Vtb_ppu | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_ppu.sv */
module tb_ppu;

  localparam int RAND_REQ = 2000;
  localparam int SPECIAL_ROUNDS = 8;
  localparam int SAT_REQ = 6;
  localparam int BP_REQ = 6;
  localparam int TOTAL_REQ = RAND_REQ + SPECIAL_ROUNDS * 15 + SAT_REQ + BP_REQ;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_REQ + 1000;

  localparam logic [7:0] NAR = 8'h80;
  localparam logic [7:0] ZERO = 8'h00;

  logic clk = 1'b0;
  logic rst_n;
  logic in_valid;
  ppu_pkg::operation_e op;
  posit_pkg::posit_word_u a_word;
  posit_pkg::posit_word_u b_word;
  logic in_credit;
  logic out_valid;
  posit_pkg::posit_word_u result_word;
  logic out_credit = 1'b0;

  logic hold_credits = 1'b0;
  logic throttle = 1'b0;
  int sent_count = 0;
  int returned_count = 0;
  int received_count = 0;
  int given_count = 0;
  int cycle_count = 0;
  int mismatch_errors = 0;
  int protocol_errors = 0;

  logic [7:0] expected_q[$];
  logic [17:0] request_q[$];

  ppu i_dut (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .in_valid_i   (in_valid),
    .op_i         (op),
    .a_i          (a_word),
    .b_i          (b_word),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .result_o     (result_word),
    .out_credit_i (out_credit)
  );

  always #4 clk = ~clk;

  // value of a posit<8,0> word, NaR excluded
  function automatic real posit_value(input logic [7:0] p);
    logic [7:0] m;
    int run;
    int i;
    int k;
    real frac;
    real step;
    real scale;
    if (p == ZERO) begin
      return 0.0;
    end
    m = p[7] ? -p : p;
    run = 0;
    i = 6;
    while (i >= 0 && m[i] == m[6]) begin
      run++;
      i--;
    end
    k = m[6] ? run - 1 : -run;
    // terminator bit
    i--;
    frac = 1.0;
    step = 0.5;
    while (i >= 0) begin
      if (m[i]) begin
        frac = frac + step;
      end
      step = step / 2.0;
      i--;
    end
    scale = 1.0;
    if (k >= 0) begin
      repeat (k) scale = scale * 2.0;
    end else begin
      repeat (-k) scale = scale / 2.0;
    end
    return p[7] ? -(frac * scale) : frac * scale;
  endfunction

  // nearest posit by exhaustive scan, ties to the even pattern
  function automatic logic [7:0] ref_result(input ppu_pkg::operation_e op_v,
                                            input logic [7:0] a_v, input logic [7:0] b_v);
    real x;
    real y;
    real r;
    real d;
    real best_d;
    logic [7:0] best;
    if (a_v == NAR || b_v == NAR) begin
      return NAR;
    end
    if (op_v == ppu_pkg::DIV && b_v == ZERO) begin
      return NAR;
    end
    x = posit_value(a_v);
    y = posit_value(b_v);
    case (op_v)
      ppu_pkg::ADD: r = x + y;
      ppu_pkg::SUB: r = x - y;
      ppu_pkg::MUL: r = x * y;
      default: r = x / y;
    endcase
    if (r == 0.0) begin
      return ZERO;
    end
    best = 8'h01;
    best_d = -1.0;
    for (int p = 1; p < 256; p++) begin
      if (p != 128) begin
        d = posit_value(8'(p)) - r;
        if (d < 0.0) begin
          d = -d;
        end
        if (best_d < 0.0 || d < best_d || (d == best_d && p % 2 == 0)) begin
          best = 8'(p);
          best_d = d;
        end
      end
    end
    return best;
  endfunction

  function automatic logic [7:0] random_regular();
    logic [7:0] v;
    v = 8'($urandom());
    while (v == ZERO || v == NAR) begin
      v = 8'($urandom());
    end
    return v;
  endfunction

  // called right after a falling edge, waits for a requester credit
  task automatic send_request(input ppu_pkg::operation_e op_v, input logic [7:0] a_v,
                              input logic [7:0] b_v, input logic [7:0] exp_v);
    while (sent_count - returned_count >= ppu_pkg::QUEUE_DEPTH) begin
      @(negedge clk);
    end
    in_valid = 1'b1;
    op = op_v;
    a_word.bits = a_v;
    b_word.bits = b_v;
    expected_q.push_back(exp_v);
    request_q.push_back({op_v, a_v, b_v});
    sent_count++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected_q.size() != 0 || received_count != given_count) begin
      @(negedge clk);
    end
  endtask

  // compare each result against the oldest expected word
  always @(posedge clk) begin
    logic [7:0] exp_w;
    logic [17:0] req;
    if (rst_n) begin
      if (out_valid !== in_credit) begin
        protocol_errors++;
        $display("out_valid_o and in_credit_o differ at time %0t", $time);
      end
      if (in_credit) begin
        returned_count++;
      end
      if (out_valid) begin
        received_count++;
        if (received_count - given_count > ppu_pkg::OUT_CREDITS) begin
          protocol_errors++;
          $display("unit used more downstream credits than granted at time %0t", $time);
        end
        if (expected_q.size() == 0) begin
          protocol_errors++;
          $display("result arrived with no request outstanding at time %0t", $time);
        end else begin
          exp_w = expected_q.pop_front();
          req = request_q.pop_front();
          if (result_word.bits !== exp_w) begin
            mismatch_errors++;
            $display("CHECK FAILED at time %0t: op %0d a %h b %h expected %h got %h",
                     $time, req[17:16], req[15:8], req[7:0], exp_w, result_word.bits);
          end
        end
      end
    end
  end

  // consumer frees one slot per cycle at most
  always @(negedge clk) begin
    out_credit = 1'b0;
    if (rst_n && !hold_credits && received_count > given_count
        && (!throttle || cycle_count % 3 == 0)) begin
      out_credit = 1'b1;
      given_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    logic [7:0] x;
    ppu_pkg::operation_e op_v;
    int base;
    void'($urandom(36));
    rst_n = 1'b0;
    in_valid = 1'b0;
    op = ppu_pkg::ADD;
    a_word.bits = ZERO;
    b_word.bits = ZERO;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (5) begin
      @(negedge clk);
      if (out_valid || in_credit) begin
        protocol_errors++;
        $display("out_valid_o or in_credit_o high before any request at time %0t", $time);
      end
    end

    for (int i = 0; i < RAND_REQ; i++) begin
      // slow consumer for the second half, longer queue residency
      throttle = (i >= RAND_REQ / 2);
      op_v = ppu_pkg::operation_e'(2'($urandom_range(3, 0)));
      a_word.bits = 8'($urandom());
      b_word.bits = 8'($urandom());
      send_request(op_v, a_word.bits, b_word.bits,
                   ref_result(op_v, a_word.bits, b_word.bits));
      if ($urandom_range(3, 0) == 0) begin
        @(negedge clk);
      end
    end
    throttle = 1'b0;

    repeat (SPECIAL_ROUNDS) begin
      x = random_regular();
      for (int k = 0; k < 4; k++) begin
        op_v = ppu_pkg::operation_e'(2'(k));
        send_request(op_v, NAR, x, NAR);
        send_request(op_v, x, NAR, NAR);
      end
      send_request(ppu_pkg::DIV, x, ZERO, NAR);
      send_request(ppu_pkg::DIV, ZERO, ZERO, NAR);
      send_request(ppu_pkg::MUL, ZERO, x, ZERO);
      send_request(ppu_pkg::MUL, x, ZERO, ZERO);
      send_request(ppu_pkg::SUB, x, x, ZERO);
      send_request(ppu_pkg::ADD, x, ZERO, x);
      send_request(ppu_pkg::ADD, ZERO, x, x);
    end

    // maxpos 7f, minpos 01 and their negatives
    send_request(ppu_pkg::MUL, 8'h7f, 8'h7f, 8'h7f);
    send_request(ppu_pkg::MUL, 8'h01, 8'h01, 8'h01);
    send_request(ppu_pkg::MUL, 8'h81, 8'h7f, 8'h81);
    send_request(ppu_pkg::MUL, 8'h81, 8'h81, 8'h7f);
    send_request(ppu_pkg::MUL, 8'hff, 8'h01, 8'hff);
    send_request(ppu_pkg::MUL, 8'hff, 8'hff, 8'h01);

    wait_drain();
    hold_credits = 1'b1;
    base = received_count;
    for (int i = 0; i < BP_REQ; i++) begin
      a_word.bits = 8'($urandom());
      b_word.bits = 8'($urandom());
      send_request(ppu_pkg::ADD, a_word.bits, b_word.bits,
                   ref_result(ppu_pkg::ADD, a_word.bits, b_word.bits));
    end
    repeat (20) @(negedge clk);
    if (received_count - base > ppu_pkg::OUT_CREDITS) begin
      protocol_errors++;
      $display("%0d results left the unit while downstream credits were withheld",
               received_count - base);
    end
    hold_credits = 1'b0;
    wait_drain();
    repeat (5) @(negedge clk);

    $display("errors: %0d value mismatches, %0d protocol errors",
             mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* ppu_sva.sv */
module ppu_sva (
  input logic                                clk,
  input logic                                rst_n_i,
  input logic                                wr_i,
  input logic                                out_valid_i,
  input logic                                out_credit_i,
  input logic [ppu_pkg::COUNT_BITS-1:0]      count_i,
  input logic [ppu_pkg::CREDIT_BITS-1:0]     credits_i
);

  // spending the last downstream credit blocks the next pop
  pop_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (out_valid_i && credits_i == ppu_pkg::CREDIT_BITS'(1) && !out_credit_i)
      |=> !out_valid_i
  ) else $error("result popped with no downstream credit");

  // requester credits keep a full queue from being written
  no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wr_i |-> (count_i != ppu_pkg::COUNT_BITS'(ppu_pkg::QUEUE_DEPTH))
  ) else $error("write into a full result queue");

  // consumer never returns more than it was granted
  credits_within_grant: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    credits_i <= ppu_pkg::CREDIT_BITS'(ppu_pkg::OUT_CREDITS)
  ) else $error("downstream credit count above its reset value");

endmodule

bind ppu_result_queue ppu_sva i_sva (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .wr_i         (wr_i),
  .out_valid_i  (out_valid_o),
  .out_credit_i (out_credit_i),
  .count_i      (count),
  .credits_i    (credits)
);

/* ppu.sv */
module ppu (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       in_valid_i,
  input  ppu_pkg::operation_e        op_i,
  input  posit_pkg::posit_word_u     a_i,
  input  posit_pkg::posit_word_u     b_i,
  output logic                       in_credit_o,
  output logic                       out_valid_o,
  output posit_pkg::posit_word_u     result_o,
  input  logic                       out_credit_i
);

  logic a_zero, a_nar, a_sign;
  logic b_zero, b_nar, b_sign;
  logic signed [posit_pkg::TE_BITS-1:0] a_te, b_te, core_te;
  logic [posit_pkg::MANT_SIZE-1:0] a_mant, b_mant;
  logic [posit_pkg::FRAC_FULL_SIZE-1:0] core_frac;
  logic core_sign, core_trunc, core_zero;
  posit_pkg::posit_word_u enc_word;

  posit_decode i_dec_a (
    .word_i (a_i), .is_zero_o (a_zero), .is_nar_o (a_nar),
    .sign_o (a_sign), .te_o (a_te), .mant_o (a_mant)
  );

  posit_decode i_dec_b (
    .word_i (b_i), .is_zero_o (b_zero), .is_nar_o (b_nar),
    .sign_o (b_sign), .te_o (b_te), .mant_o (b_mant)
  );

  core_op i_core (
    .op_i (op_i), .sign1_i (a_sign), .sign2_i (b_sign),
    .te1_i (a_te), .te2_i (b_te), .mant1_i (a_mant), .mant2_i (b_mant),
    .sign_o (core_sign), .te_o (core_te), .frac_o (core_frac),
    .frac_truncated_o (core_trunc), .is_zero_o (core_zero)
  );

  posit_encode i_enc (
    .sign_i (core_sign), .te_i (core_te), .frac_i (core_frac),
    .frac_truncated_i (core_trunc), .core_zero_i (core_zero),
    .a_zero_i (a_zero), .b_zero_i (b_zero), .a_nar_i (a_nar), .b_nar_i (b_nar),
    .op_i (op_i), .word_o (enc_word)
  );

  // accepted request goes straight into the queue
  ppu_result_queue i_queue (
    .clk (clk), .rst_n_i (rst_n_i),
    .wr_i (in_valid_i), .wr_data_i (enc_word),
    .out_credit_i (out_credit_i), .out_valid_o (out_valid_o),
    .out_data_o (result_o), .in_credit_o (in_credit_o)
  );

endmodule

/* ppu_result_queue.sv */
module ppu_result_queue (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       wr_i,
  input  posit_pkg::posit_word_u     wr_data_i,
  input  logic                       out_credit_i,
  output logic                       out_valid_o,
  output posit_pkg::posit_word_u     out_data_o,
  output logic                       in_credit_o
);

  posit_pkg::posit_word_u mem [ppu_pkg::QUEUE_DEPTH];

  logic [ppu_pkg::PTR_BITS-1:0] wr_ptr;
  logic [ppu_pkg::PTR_BITS-1:0] rd_ptr;
  logic [ppu_pkg::COUNT_BITS-1:0] count;
  logic [ppu_pkg::CREDIT_BITS-1:0] credits;
  logic pop;

  // one pop per cycle while data and a downstream credit are both there
  assign pop = (count != '0) && (credits != '0);
  assign out_valid_o = pop;
  assign in_credit_o = pop;
  assign out_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_i, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // pop and credit return may land in the same cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits <= ppu_pkg::CREDIT_BITS'(ppu_pkg::OUT_CREDITS);
    end else begin
      credits <= credits - {{(ppu_pkg::CREDIT_BITS-1){1'b0}}, pop}
                         + {{(ppu_pkg::CREDIT_BITS-1){1'b0}}, out_credit_i};
    end
  end

endmodule

/* posit_encode.sv */
module posit_encode (
  input  logic                                   sign_i,
  input  logic signed [posit_pkg::TE_BITS-1:0]   te_i,
  input  logic [posit_pkg::FRAC_FULL_SIZE-1:0]   frac_i,
  input  logic                                   frac_truncated_i,
  input  logic                                   core_zero_i,
  input  logic                                   a_zero_i,
  input  logic                                   b_zero_i,
  input  logic                                   a_nar_i,
  input  logic                                   b_nar_i,
  input  ppu_pkg::operation_e                    op_i,
  output posit_pkg::posit_word_u                 word_o
);

  logic [8:0] regime;
  logic [3:0] reg_len;
  logic [3:0] ones;
  logic [23:0] stream;
  logic [posit_pkg::N-2:0] body;
  logic [posit_pkg::N-2:0] body_r;
  logic [posit_pkg::N-1:0] mag;
  logic guard;
  logic sticky;
  logic round_up;
  logic res_nar;
  logic res_zero;

  assign res_nar = a_nar_i || b_nar_i || (op_i == ppu_pkg::DIV && b_zero_i);
  assign res_zero = core_zero_i
                 || (op_i == ppu_pkg::MUL && (a_zero_i || b_zero_i))
                 || (op_i == ppu_pkg::DIV && a_zero_i);

  always_comb begin
    ones = '0;
    if (te_i >= 0) begin
      // k+1 ones then a zero
      ones = {1'b0, te_i[2:0]} + 4'd1;
      regime = ((9'd1 << ones) - 9'd1) << 1;
      reg_len = ones + 4'd1;
    end else begin
      regime = 9'd1;
      reg_len = 4'(-te_i) + 4'd1;
    end
    // regime to the top, fraction right behind it
    stream = {regime, frac_i, 1'b0} << (4'd9 - reg_len);
    body = stream[23 -: posit_pkg::N-1];
    guard = stream[16];
    sticky = (|stream[15:0]) | frac_truncated_i;
    round_up = guard & (sticky | body[0]);
    body_r = body + {6'b0, round_up};
    // saturate, never to zero or NaR
    if (te_i > posit_pkg::MAXPOS_TE) begin
      body_r = 7'h7f;
    end else if (te_i < -posit_pkg::MAXPOS_TE) begin
      body_r = 7'h01;
    end
    mag = {1'b0, body_r};
    if (res_nar) begin
      word_o.bits = posit_pkg::NAR_BITS;
    end else if (res_zero) begin
      word_o.bits = posit_pkg::ZERO_BITS;
    end else begin
      word_o.bits = sign_i ? -mag : mag;
    end
  end

endmodule

/* core_op.sv */
module core_op (
  input  ppu_pkg::operation_e                          op_i,
  input  logic                                         sign1_i,
  input  logic                                         sign2_i,
  input  logic signed [posit_pkg::TE_BITS-1:0]         te1_i,
  input  logic signed [posit_pkg::TE_BITS-1:0]         te2_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]              mant1_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]              mant2_i,
  output logic                                         sign_o,
  output logic signed [posit_pkg::TE_BITS-1:0]         te_o,
  output logic [posit_pkg::FRAC_FULL_SIZE-1:0]         frac_o,
  output logic                                         frac_truncated_o,
  output logic                                         is_zero_o
);

  logic [posit_pkg::MANT_ADD_RESULT_SIZE-1:0] mant_as;
  logic [posit_pkg::MANT_MUL_RESULT_SIZE-1:0] prod;
  logic [posit_pkg::MANT_DIV_RESULT_SIZE-1:0] mant_div;
  logic signed [posit_pkg::TE_BITS-1:0] te_as;
  logic signed [posit_pkg::TE_BITS-1:0] te_div;
  logic signed [posit_pkg::TE_BITS+1:0] te_add_w;
  logic signed [posit_pkg::TE_BITS+1:0] te_mul_w;
  logic trunc_as;
  logic trunc_div;
  logic sign2_eff;
  logic a_big;
  logic is_add_sub;

  assign is_add_sub = (op_i == ppu_pkg::ADD) || (op_i == ppu_pkg::SUB);
  assign sign2_eff = sign2_i ^ (op_i == ppu_pkg::SUB);
  assign a_big = (te1_i > te2_i) || (te1_i == te2_i && mant1_i >= mant2_i);

  core_add_sub i_add_sub (
    .te1_i            (te1_i),
    .te2_i            (te2_i),
    .mant1_i          (mant1_i),
    .mant2_i          (mant2_i),
    .opposite_sign_i  (sign1_i ^ sign2_eff),
    .mant_o           (mant_as),
    .te_o             (te_as),
    .frac_truncated_o (trunc_as)
  );

  core_div i_div (
    .te1_i            (te1_i),
    .te2_i            (te2_i),
    .mant1_i          (mant1_i),
    .mant2_i          (mant2_i),
    .mant_o           (mant_div),
    .te_o             (te_div),
    .frac_truncated_o (trunc_div)
  );

  // product in [1,4), one-bit normalisation below
  assign prod = mant1_i * mant2_i;
  assign te_add_w = te_as + (mant_as[7] ? 6'sd1 : 6'sd0);
  assign te_mul_w = te1_i + te2_i + (prod[11] ? 6'sd1 : 6'sd0);

  always_comb begin
    case (op_i)
      ppu_pkg::MUL: begin
        frac_o = prod[11] ? {prod[10:0], 3'b0} : {prod[9:0], 4'b0};
        te_o = posit_pkg::clamp_te(te_mul_w);
        frac_truncated_o = 1'b0;
      end
      ppu_pkg::DIV: begin
        frac_o = mant_div;
        te_o = te_div;
        frac_truncated_o = trunc_div;
      end
      default: begin
        // drop the integer bits of the add/sub result
        frac_o = mant_as[7] ? {mant_as[6:0], 7'b0} : {mant_as[5:0], 8'b0};
        te_o = posit_pkg::clamp_te(te_add_w);
        frac_truncated_o = trunc_as;
      end
    endcase
  end

  assign sign_o = is_add_sub ? (a_big ? sign1_i : sign2_eff) : (sign1_i ^ sign2_i);
  assign is_zero_o = is_add_sub && (mant_as == '0);

endmodule

/* core_div.sv */
module core_div (
  input  logic signed [posit_pkg::TE_BITS-1:0]          te1_i,
  input  logic signed [posit_pkg::TE_BITS-1:0]          te2_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]               mant1_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]               mant2_i,
  output logic [posit_pkg::MANT_DIV_RESULT_SIZE-1:0]    mant_o,
  output logic signed [posit_pkg::TE_BITS-1:0]          te_o,
  output logic                                          frac_truncated_o
);

  logic [posit_pkg::DIV_QUOT_RAW_SIZE-1:0] q;
  logic [posit_pkg::MANT_SIZE+1:0] rem;
  logic [posit_pkg::MANT_SIZE+1:0] divisor;
  logic signed [posit_pkg::TE_BITS+1:0] te_w;

  assign divisor = {2'b00, mant2_i};

  always_comb begin
    rem = {2'b00, mant1_i};
    q = '0;
    // restoring division, msb of q is the integer bit
    for (int i = posit_pkg::DIV_QUOT_RAW_SIZE - 1; i >= 0; i--) begin
      if (rem >= divisor) begin
        q[i] = 1'b1;
        rem = rem - divisor;
      end
      rem = rem << 1;
    end
    te_w = te1_i - te2_i;
    if (q[posit_pkg::DIV_QUOT_RAW_SIZE-1]) begin
      mant_o = q[14:1];
      frac_truncated_o = q[0] | (rem != '0);
    end else begin
      // quotient below one
      mant_o = q[13:0];
      frac_truncated_o = (rem != '0);
      te_w = te_w - 6'sd1;
    end
    te_o = posit_pkg::clamp_te(te_w);
  end

endmodule

/* core_add_sub.sv */
module core_add_sub (
  input  logic signed [posit_pkg::TE_BITS-1:0]          te1_i,
  input  logic signed [posit_pkg::TE_BITS-1:0]          te2_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]               mant1_i,
  input  logic [posit_pkg::MANT_SIZE-1:0]               mant2_i,
  input  logic                                          opposite_sign_i,
  output logic [posit_pkg::MANT_ADD_RESULT_SIZE-1:0]    mant_o,
  output logic signed [posit_pkg::TE_BITS-1:0]          te_o,
  output logic                                          frac_truncated_o
);

  logic a_big;
  logic signed [posit_pkg::TE_BITS-1:0] te_big;
  logic [posit_pkg::TE_BITS-1:0] diff;
  logic [posit_pkg::MANT_SIZE-1:0] m_big;
  logic [posit_pkg::MANT_SIZE-1:0] m_small;
  logic [posit_pkg::ADD_EXT_SIZE-1:0] big_ext;
  logic [posit_pkg::ADD_EXT_SIZE-1:0] small_sh;
  logic [posit_pkg::ADD_EXT_SIZE-1:0] sum;
  logic [posit_pkg::ADD_EXT_SIZE-1:0] sum_n;
  logic [2*posit_pkg::ADD_EXT_SIZE-1:0] sh_full;
  logic [3:0] lead;
  logic [3:0] shift;
  logic stk;

  assign a_big = (te1_i > te2_i) || (te1_i == te2_i && mant1_i >= mant2_i);

  always_comb begin
    if (a_big) begin
      te_big = te1_i;
      diff = te1_i - te2_i;
      m_big = mant1_i;
      m_small = mant2_i;
    end else begin
      te_big = te2_i;
      diff = te2_i - te1_i;
      m_big = mant2_i;
      m_small = mant1_i;
    end
    // hidden one sits at bit ADD_EXT_SIZE-3
    big_ext = {2'b00, m_big, 8'b0};
    sh_full = {2'b00, m_small, 8'b0, 16'b0} >> diff;
    small_sh = sh_full[2*posit_pkg::ADD_EXT_SIZE-1 -: posit_pkg::ADD_EXT_SIZE];
    stk = |sh_full[posit_pkg::ADD_EXT_SIZE-1:0];
    // lost bits on subtract: take one more lsb off, keep sticky
    if (opposite_sign_i) begin
      sum = big_ext - small_sh - {15'b0, stk};
    end else begin
      sum = big_ext + small_sh;
    end
    lead = '0;
    for (int i = 0; i < posit_pkg::ADD_EXT_SIZE; i++) begin
      if (sum[i]) begin
        lead = 4'(i);
      end
    end
    // cancellation: bring the leading one back to the hidden position
    shift = (lead < 4'd13) ? 4'd13 - lead : 4'd0;
    sum_n = sum << shift;
    te_o = te_big - shift;
    mant_o = sum_n[14 -: posit_pkg::MANT_ADD_RESULT_SIZE];
    frac_truncated_o = stk | (|sum_n[6:0]);
  end

endmodule

/* posit_decode.sv */
module posit_decode (
  input  posit_pkg::posit_word_u                word_i,
  output logic                                  is_zero_o,
  output logic                                  is_nar_o,
  output logic                                  sign_o,
  output logic signed [posit_pkg::TE_BITS-1:0]  te_o,
  output logic [posit_pkg::MANT_SIZE-1:0]       mant_o
);

  logic [posit_pkg::N-1:0] mag;
  logic [posit_pkg::N-2:0] body;
  logic [posit_pkg::N-2:0] rest;
  logic [3:0] run;
  logic stop;

  assign is_zero_o = (word_i.bits == posit_pkg::ZERO_BITS);
  assign is_nar_o = (word_i.bits == posit_pkg::NAR_BITS);
  assign sign_o = word_i.fields.sign;

  always_comb begin
    mag = word_i.fields.sign ? -word_i.bits : word_i.bits;
    body = mag[posit_pkg::N-2:0];
    run = '0;
    stop = 1'b0;
    // length of the regime run
    for (int i = posit_pkg::N - 2; i >= 0; i--) begin
      if (!stop && body[i] == body[posit_pkg::N-2]) begin
        run = run + 4'd1;
      end else begin
        stop = 1'b1;
      end
    end
    // skip run and terminator, fraction is left-aligned
    rest = body << (run + 4'd1);
    if (body[posit_pkg::N-2]) begin
      te_o = $signed(run) - 4'sd1;
    end else begin
      te_o = -$signed(run);
    end
    // zero carries no hidden one so add/sub passes the other operand through
    mant_o = {~is_zero_o, rest[posit_pkg::N-2 -: posit_pkg::MANT_SIZE-1]};
  end

endmodule

/* ppu_pkg.sv */
package ppu_pkg;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } operation_e;

  // queue depth doubles as the requester's initial credit count
  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_BITS = $clog2(OUT_CREDITS + 1);

endpackage

/* posit_pkg.sv */
package posit_pkg;

  // posit<8,0>, no exponent field
  localparam int N = 8;
  localparam int TE_BITS = 4;
  localparam int MANT_SIZE = 6;

  localparam int MANT_ADD_RESULT_SIZE = 8;
  localparam int MANT_MUL_RESULT_SIZE = 12;
  localparam int MANT_DIV_RESULT_SIZE = 14;
  localparam int FRAC_FULL_SIZE = 14;

  // working widths inside add/sub and divide
  localparam int ADD_EXT_SIZE = 16;
  localparam int DIV_QUOT_RAW_SIZE = 16;

  localparam logic [N-1:0] NAR_BITS = 8'h80;
  localparam logic [N-1:0] ZERO_BITS = 8'h00;

  localparam int MAXPOS_TE = 6;

  typedef union packed {
    logic [N-1:0] bits;
    struct packed {
      logic sign;
      logic [N-2:0] body;
    } fields;
  } posit_word_u;

  // anything past maxpos or minpos saturates in the encoder anyway
  function automatic logic signed [TE_BITS-1:0] clamp_te(input logic signed [TE_BITS+1:0] te);
    if (te > MAXPOS_TE + 1) begin
      return TE_BITS'(MAXPOS_TE + 1);
    end else if (te < -(MAXPOS_TE + 1)) begin
      return TE_BITS'(-(MAXPOS_TE + 1));
    end
    return te[TE_BITS-1:0];
  endfunction

endpackage
